// File: ring_cache.f
design/cache_pkg.sv
design/ring_pkg.sv
design/mem_if.sv
design/ring_if.sv
design/ring_cache.sv
design/mem_interconnect.sv
design/cache_ring.sv
testbench/cache_ring_sva.sv
testbench/tb_mem_model.sv
testbench/tb_cache_ring.sv

// File: Bender.yml
package:
  name: ring_cache

sources:
  - design/cache_pkg.sv
  - design/ring_pkg.sv
  - design/mem_if.sv
  - design/ring_if.sv
  - design/ring_cache.sv
  - design/mem_interconnect.sv
  - design/cache_ring.sv
  - target: test
    files:
      - testbench/cache_ring_sva.sv
      - testbench/tb_mem_model.sv
      - testbench/tb_cache_ring.sv

// File: testbench/tb_cache_ring.sv
`timescale 1ns/1ps

module tb_cache_ring;

	localparam int NODES = 4;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 5;
	localparam int ACCESSES = 66;                             // core accesses over all tests
	localparam int ACCESS_BOUND = 200;                        // worst case cycles per access
	localparam int TIMEOUT_NS = (RESET_CYCLES + ACCESSES * ACCESS_BOUND) * CLK_PERIOD;

	logic clk = 1'b0;
	logic reset;
	logic stall_en;
	cache_pkg::word_addr_t core_address [NODES];
	logic core_read [NODES];
	logic core_write [NODES];
	logic [31:0] core_writedata [NODES];
	logic [3:0] core_byteenable [NODES];
	logic [31:0] core_readdata [NODES];
	logic core_waitrequest [NODES];
	logic [31:0] mem_address;
	logic mem_read;
	logic mem_write;
	logic [127:0] mem_writedata;
	logic [15:0] mem_byteenable;
	logic [127:0] mem_readdata;
	logic mem_waitrequest;

	always #(CLK_PERIOD / 2) clk = ~clk;

	cache_ring #(
		.NODES(NODES),
		.INDEX_BITS(4)
	) dut_i (
		.clk(clk),
		.reset(reset),
		.core_address(core_address),
		.core_read(core_read),
		.core_write(core_write),
		.core_writedata(core_writedata),
		.core_byteenable(core_byteenable),
		.core_readdata(core_readdata),
		.core_waitrequest(core_waitrequest),
		.mem_address(mem_address),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_writedata(mem_writedata),
		.mem_byteenable(mem_byteenable),
		.mem_readdata(mem_readdata),
		.mem_waitrequest(mem_waitrequest)
	);

	tb_mem_model mem_i (
		.clk(clk),
		.reset(reset),
		.stall_en(stall_en),
		.address(mem_address),
		.read(mem_read),
		.write(mem_write),
		.writedata(mem_writedata),
		.byteenable(mem_byteenable),
		.readdata(mem_readdata),
		.waitrequest(mem_waitrequest)
	);

	// power-on content of memory, word address based
	function automatic logic [31:0] initial_word(input cache_pkg::word_addr_t addr);
		return (32'(addr) * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
	endfunction

	function automatic logic [31:0] merge_bytes(input logic [31:0] old_word,
			input logic [31:0] new_word, input logic [3:0] be);
		logic [31:0] result;
		result = old_word;
		for (int b = 0; b < 4; b++) begin
			if (be[b])
				result[b * 8 +: 8] = new_word[b * 8 +: 8];
		end
		return result;
	endfunction

	function automatic logic [31:0] mem_word(input cache_pkg::word_addr_t addr);
		return mem_i.store[addr[11:2]][{addr[1:0], 5'b00000} +: 32];
	endfunction

	task automatic check_value(input string name, input logic [127:0] expected,
			input logic [127:0] actual);
		if (actual !== expected) begin
			$display("[ERROR] %s: expected %0h, actual %0h", name, expected, actual);
			$display("Test failed");
			$fatal(1, "value mismatch");
		end
	endtask

	// one core request, held until waitrequest drops
	task automatic core_access(input int c, input logic wr, input cache_pkg::word_addr_t addr,
			input logic [31:0] wdata, input logic [3:0] be, output logic [31:0] rdata,
			output int cycles);
		@(posedge clk);
		core_address[c] <= addr;
		core_read[c] <= !wr;
		core_write[c] <= wr;
		core_writedata[c] <= wdata;
		core_byteenable[c] <= be;
		cycles = 0;
		@(negedge clk);
		while (core_waitrequest[c]) begin
			@(posedge clk);
			cycles++;
			@(negedge clk);
		end
		rdata = core_readdata[c];
		@(posedge clk);
		core_read[c] <= 1'b0;
		core_write[c] <= 1'b0;
	endtask

	task automatic read_expect(input string name, input int c, input cache_pkg::word_addr_t addr,
			input logic [31:0] expected);
		logic [31:0] data;
		int cycles;
		core_access(c, 1'b0, addr, '0, '0, data, cycles);
		check_value($sformatf("%s core %0d", name, c), expected, data);
	endtask

	task automatic write_word(input int c, input cache_pkg::word_addr_t addr,
			input logic [31:0] data, input logic [3:0] be);
		logic [31:0] unused_data;
		int cycles;
		core_access(c, 1'b1, addr, data, be, unused_data, cycles);
	endtask

	task automatic check_line(input string name, input int c, input cache_pkg::word_addr_t base,
			input logic [31:0] vals [4]);
		for (int w = 0; w < 4; w++)
			read_expect(name, c, base + 30'(w), vals[w]);
	endtask

	task automatic read_miss_hit(input cache_pkg::word_addr_t addr);
		logic [31:0] data;
		int cycles;
		core_access(0, 1'b0, addr, '0, '0, data, cycles);
		check_value("read_miss_hit", initial_word(addr), data);
		core_access(0, 1'b0, addr, '0, '0, data, cycles);
		check_value("read_miss_hit", initial_word(addr), data);
		check_value("read_miss_hit latency", 2, cycles);  // hit answers in two cycles
	endtask

	task automatic write_read_own(input string prefix, input cache_pkg::word_addr_t addr);
		string name;
		logic [31:0] data;
		logic [31:0] expected;
		name = {prefix, "write_read_own"};
		data = 32'h5aa5_c33c ^ 32'(addr);
		expected = merge_bytes(initial_word(addr), data, 4'b0110);
		read_expect(name, 0, addr, initial_word(addr));  // line now cached
		write_word(0, addr, data, 4'b0110);
		read_expect(name, 0, addr, expected);
		check_value({name, " memory"}, expected, mem_word(addr));
	endtask

	task automatic coherence(input string prefix, input cache_pkg::word_addr_t addr);
		string name;
		logic [31:0] value;
		name = {prefix, "coherence"};
		value = ~initial_word(addr);
		fork
			read_expect(name, 1, addr, initial_word(addr));
			read_expect(name, 2, addr, initial_word(addr));
		join
		write_word(3, addr, value, 4'hf);
		fork
			read_expect(name, 1, addr, value);
			read_expect(name, 2, addr, value);
		join
	endtask

	task automatic concurrent_writes(input string prefix, input cache_pkg::word_addr_t base);
		string name;
		logic [31:0] vals [4];
		name = {prefix, "concurrent_writes"};
		for (int c = 0; c < NODES; c++)
			vals[c] = (32'h1000_0001 * (c + 1)) ^ 32'(base);
		fork
			read_expect(name, 0, base, initial_word(base));
			read_expect(name, 1, base + 30'd1, initial_word(base + 30'd1));
			read_expect(name, 2, base + 30'd2, initial_word(base + 30'd2));
			read_expect(name, 3, base + 30'd3, initial_word(base + 30'd3));
		join
		fork
			write_word(0, base, vals[0], 4'hf);
			write_word(1, base + 30'd1, vals[1], 4'hf);
			write_word(2, base + 30'd2, vals[2], 4'hf);
			write_word(3, base + 30'd3, vals[3], 4'hf);
		join
		fork
			check_line(name, 0, base, vals);
			check_line(name, 1, base, vals);
			check_line(name, 2, base, vals);
			check_line(name, 3, base, vals);
		join
		for (int w = 0; w < 4; w++)
			check_value({name, " memory"}, vals[w], mem_word(base + 30'(w)));
	endtask

	initial begin : watchdog
		#(TIMEOUT_NS);
		$display("watchdog expired after %0d ns, a core access never completed", TIMEOUT_NS);
		$display("Test failed");
		$fatal(1, "timeout");
	end

	initial begin
		reset = 1'b1;
		stall_en = 1'b0;
		for (int c = 0; c < NODES; c++) begin
			core_address[c] = '0;
			core_read[c] = 1'b0;
			core_write[c] = 1'b0;
			core_writedata[c] = '0;
			core_byteenable[c] = '0;
		end
		repeat (RESET_CYCLES) @(posedge clk);
		reset <= 1'b0;

		read_miss_hit(30'h041);
		write_read_own("", 30'h103);
		coherence("", 30'h126);
		concurrent_writes("", 30'h150);

		@(posedge clk);
		stall_en <= 1'b1;                                     // memory now stalls at random
		write_read_own("backpressure/", 30'h803);
		coherence("backpressure/", 30'h826);
		concurrent_writes("backpressure/", 30'h850);

		$display("Test passed");
		$finish;
	end

endmodule

// File: testbench/tb_mem_model.sv
`timescale 1ns/1ps

module tb_mem_model #(
	parameter int LINES = 1024
) (
	input  logic clk,
	input  logic reset,
	input  logic stall_en,                                    // random waitrequest on
	input  logic [31:0] address,
	input  logic read,
	input  logic write,
	input  logic [127:0] writedata,
	input  logic [15:0] byteenable,
	output logic [127:0] readdata,
	output logic waitrequest
);

	localparam int INDEX_BITS = $clog2(LINES);

	logic [127:0] store [LINES];
	logic [31:0] lfsr;
	logic [INDEX_BITS-1:0] index;

	function automatic logic [31:0] init_word(input logic [29:0] word_addr);
		return (32'(word_addr) * 32'h9e37_79b1) ^ 32'hc3a5_5a3c;
	endfunction

	// fibonacci, taps 32 22 2 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	initial begin
		for (int i = 0; i < LINES; i++)
			for (int w = 0; w < 4; w++)
				store[i][w * 32 +: 32] = init_word(30'(i * 4 + w));
	end

	assign index = address[INDEX_BITS+3:4];                   // line aligned byte address
	assign readdata = read ? store[index] : '0;
	assign waitrequest = stall_en && lfsr[0];

	always @(posedge clk) begin
		if (reset)
			lfsr <= 32'h5b65;
		else if (stall_en)
			lfsr <= lfsr_next(lfsr);                          // one step per bit taken
	end

	always @(posedge clk) begin
		if (write && !waitrequest) begin
			for (int b = 0; b < 16; b++) begin
				if (byteenable[b])
					store[index][b * 8 +: 8] <= writedata[b * 8 +: 8];
			end
		end
	end

endmodule

// File: testbench/cache_ring_sva.sv
`timescale 1ns/1ps

module cache_ring_sva #(
	parameter int NODES = 4
) (
	input  logic clk,
	input  logic reset,
	input  logic [NODES-1:0] token_valid,
	input  logic mem_read,
	input  logic mem_write,
	input  logic mem_waitrequest,
	input  logic [31:0] mem_address,
	input  logic [127:0] mem_writedata,
	input  logic [15:0] mem_byteenable
);

	// only one token on the ring
	single_token: assert property (@(posedge clk) disable iff (reset)
		$onehot0(token_valid))
		else $error("more than one node passed the token in the same cycle");

	no_read_write: assert property (@(posedge clk) disable iff (reset)
		!(mem_read && mem_write))
		else $error("memory read and write asserted together");

	// request held while stalled
	request_stable: assert property (@(posedge clk) disable iff (reset)
		(mem_read || mem_write) && mem_waitrequest |=>
		$stable({mem_read, mem_write, mem_address, mem_writedata, mem_byteenable}))
		else $error("memory request changed while waitrequest was high");

endmodule

bind cache_ring cache_ring_sva #(
	.NODES(NODES)
) sva_i (
	.clk(clk),
	.reset(reset),
	.token_valid({ring[3].token_valid, ring[2].token_valid,
		ring[1].token_valid, ring[0].token_valid}),
	.mem_read(mem_read),
	.mem_write(mem_write),
	.mem_waitrequest(mem_waitrequest),
	.mem_address(mem_address),
	.mem_writedata(mem_writedata),
	.mem_byteenable(mem_byteenable)
);

// File: design/cache_ring.sv
`timescale 1ns/1ps

module cache_ring #(
	parameter int NODES = 4,
	parameter int INDEX_BITS = 4
) (
	input  logic clk,
	input  logic reset,

	input  cache_pkg::word_addr_t core_address [NODES],
	input  logic core_read [NODES],
	input  logic core_write [NODES],
	input  logic [31:0] core_writedata [NODES],
	input  logic [3:0] core_byteenable [NODES],
	output logic [31:0] core_readdata [NODES],
	output logic core_waitrequest [NODES],

	output logic [31:0] mem_address,
	output logic mem_read,
	output logic mem_write,
	output logic [127:0] mem_writedata,
	output logic [15:0] mem_byteenable,
	input  logic [127:0] mem_readdata,
	input  logic mem_waitrequest
);

	mem_if mem_bus [NODES] ();
	ring_if ring [NODES] ();                                  // ring[i] runs from node i to i+1

	for (genvar i = 0; i < NODES; i++) begin : g_node
		ring_cache #(
			.NODE_ID(i),
			.INDEX_BITS(INDEX_BITS),
			.TOKEN_AT_RESET(i == NODES - 1)                   // last node starts with the token
		) node (
			.clk(clk),
			.reset(reset),
			.core_address(core_address[i]),
			.core_read(core_read[i]),
			.core_write(core_write[i]),
			.core_writedata(core_writedata[i]),
			.core_byteenable(core_byteenable[i]),
			.core_readdata(core_readdata[i]),
			.core_waitrequest(core_waitrequest[i]),
			.mem(mem_bus[i]),
			.ring_in(ring[(i + NODES - 1) % NODES]),
			.ring_out(ring[i])
		);
	end

	mem_interconnect #(
		.NODES(NODES)
	) interconnect_i (
		.clk(clk),
		.reset(reset),
		.node(mem_bus),
		.mem_address(mem_address),
		.mem_read(mem_read),
		.mem_write(mem_write),
		.mem_writedata(mem_writedata),
		.mem_byteenable(mem_byteenable),
		.mem_readdata(mem_readdata),
		.mem_waitrequest(mem_waitrequest)
	);

endmodule

// File: design/mem_interconnect.sv
`timescale 1ns/1ps

module mem_interconnect #(
	parameter int NODES = 4
) (
	input  logic clk,
	input  logic reset,
	mem_if.slave node [NODES],
	output logic [31:0] mem_address,
	output logic mem_read,
	output logic mem_write,
	output logic [127:0] mem_writedata,
	output logic [15:0] mem_byteenable,
	input  logic [127:0] mem_readdata,
	input  logic mem_waitrequest
);

	localparam int ID_BITS = (NODES > 1) ? $clog2(NODES) : 1;

	logic [NODES-1:0] req;
	logic [NODES-1:0] rd;
	logic [NODES-1:0] wr;
	logic [31:0] addr [NODES];
	logic [127:0] wdata [NODES];
	logic [15:0] be [NODES];

	logic [ID_BITS-1:0] prio;                                 // first node to look at
	logic [ID_BITS-1:0] grant;
	logic [ID_BITS-1:0] pick;
	logic [ID_BITS-1:0] sel;
	logic locked;                                             // access in progress
	logic found;

	for (genvar i = 0; i < NODES; i++) begin : g_port
		assign rd[i] = node[i].read;
		assign wr[i] = node[i].write;
		assign req[i] = node[i].read || node[i].write;
		assign addr[i] = node[i].address;
		assign wdata[i] = node[i].writedata;
		assign be[i] = node[i].byteenable;
		assign node[i].readdata = mem_readdata;
		// losers are stalled
		assign node[i].waitrequest = (sel == ID_BITS'(i)) ? mem_waitrequest : 1'b1;
	end

	// round robin pick starting at prio
	always_comb begin
		pick = prio;
		found = 1'b0;
		for (int k = 0; k < NODES; k++) begin
			if (!found && req[(int'(prio) + k) % NODES]) begin
				pick = ID_BITS'((int'(prio) + k) % NODES);
				found = 1'b1;
			end
		end
	end

	assign sel = locked ? grant : pick;

	assign mem_read = rd[sel];
	assign mem_write = wr[sel];
	assign mem_address = addr[sel];
	assign mem_writedata = wdata[sel];
	assign mem_byteenable = be[sel];

	always_ff @(posedge clk) begin
		if (reset) begin
			prio <= '0;
			grant <= '0;
			locked <= 1'b0;
		end else if (req[sel]) begin
			if (!mem_waitrequest) begin
				locked <= 1'b0;
				prio <= ID_BITS'((int'(sel) + 1) % NODES);    // served node goes last
			end else begin
				locked <= 1'b1;
				grant <= sel;
			end
		end
	end

endmodule

// File: design/ring_cache.sv
`timescale 1ns/1ps

module ring_cache #(
	parameter int NODE_ID = 0,
	parameter int INDEX_BITS = 4,
	parameter bit TOKEN_AT_RESET = 1'b0
) (
	input  logic clk,
	input  logic reset,
	input  cache_pkg::word_addr_t core_address,
	input  logic core_read,
	input  logic core_write,
	input  logic [31:0] core_writedata,
	input  logic [3:0] core_byteenable,
	output logic [31:0] core_readdata,
	output logic core_waitrequest,
	mem_if.master mem,
	ring_if.receive ring_in,
	ring_if.send ring_out
);

	localparam int LINES = 1 << INDEX_BITS;
	localparam int TAG_BITS = cache_pkg::LINE_ADDR_BITS - INDEX_BITS;

	cache_pkg::node_state_e state;

	logic [LINES-1:0] valid;
	logic [TAG_BITS-1:0] tags [LINES];
	cache_pkg::line_t lines [LINES];

	// latched core request
	cache_pkg::line_addr_t req_line;
	logic [cache_pkg::WORD_OFFSET_BITS-1:0] req_word;
	logic req_write;
	cache_pkg::word_t req_wdata;
	logic [cache_pkg::WORD_BYTES-1:0] req_be;
	cache_pkg::word_t rdata;
	logic fill_stale;                                         // fill hit by a snoop

	logic have_token;
	logic token_out;
	ring_pkg::ring_msg_t out_msg;
	logic out_valid;

	logic [INDEX_BITS-1:0] req_index;
	logic [TAG_BITS-1:0] req_tag;
	logic hit;
	logic take;
	logic own_back;
	logic snoop;
	logic [INDEX_BITS-1:0] snoop_index;
	logic [TAG_BITS-1:0] snoop_tag;
	logic snoop_fill;
	logic inject;
	logic token_in;
	logic keep_token;
	logic pass_token;

	assign req_index = req_line[INDEX_BITS-1:0];
	assign req_tag = req_line[cache_pkg::LINE_ADDR_BITS-1:INDEX_BITS];
	assign hit = valid[req_index] && (tags[req_index] == req_tag);

	// ring side decode
	assign take = ring_in.msg_valid && ring_in.msg_ready;
	assign own_back = take && (ring_in.msg.origin == ring_pkg::node_id_t'(NODE_ID));
	assign snoop = take && !own_back && (ring_in.msg.op == ring_pkg::OP_INV);
	assign snoop_index = ring_in.msg.addr[INDEX_BITS-1:0];
	assign snoop_tag = ring_in.msg.addr[cache_pkg::LINE_ADDR_BITS-1:INDEX_BITS];
	assign snoop_fill = snoop && (snoop_index == req_index);
	// own invalidate only goes out into an empty slot
	assign inject = (state == cache_pkg::SEND_INV) && !out_valid && !ring_in.msg_valid;

	// token is held from the write request until its invalidate returns
	assign token_in = ring_in.token_valid && ring_in.token;
	assign keep_token = (state == cache_pkg::LOOKUP && req_write) ||
		(state == cache_pkg::WAIT_TOKEN) ||
		(state == cache_pkg::MEM_WRITE) ||
		(state == cache_pkg::SEND_INV) ||
		(state == cache_pkg::WAIT_INV && !own_back);
	assign pass_token = (have_token || token_in) && !keep_token;

	assign ring_in.msg_ready = !out_valid;
	assign ring_out.msg = out_msg;
	assign ring_out.msg_valid = out_valid;
	assign ring_out.token = 1'b1;
	assign ring_out.token_valid = token_out;

	assign mem.read = (state == cache_pkg::FILL);
	assign mem.write = (state == cache_pkg::MEM_WRITE);
	assign mem.address = {req_line, {cache_pkg::BYTE_OFFSET_BITS{1'b0}}};
	assign mem.writedata = {cache_pkg::LINE_WORDS{req_wdata}};       // word replicated in all lanes
	assign mem.byteenable = 16'(req_be) << {req_word, 2'b00};

	assign core_readdata = rdata;
	assign core_waitrequest = (core_read || core_write) && (state != cache_pkg::DONE);

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= cache_pkg::IDLE;
			valid <= '0;
			fill_stale <= 1'b0;
			have_token <= TOKEN_AT_RESET;
			token_out <= 1'b0;
			out_valid <= 1'b0;
		end else begin
			have_token <= (have_token || token_in) && !pass_token;
			token_out <= pass_token;

			if (inject || (take && !own_back))
				out_valid <= 1'b1;
			else if (ring_out.msg_ready)
				out_valid <= 1'b0;                            // next hop took it

			if (snoop && valid[snoop_index] && (tags[snoop_index] == snoop_tag))
				valid[snoop_index] <= 1'b0;

			case (state)
				cache_pkg::IDLE: begin
					if (core_read || core_write)
						state <= cache_pkg::LOOKUP;
				end
				cache_pkg::LOOKUP: begin
					if (req_write) begin
						state <= cache_pkg::WAIT_TOKEN;
					end else if (hit) begin
						state <= cache_pkg::DONE;
					end else begin
						state <= cache_pkg::FILL;
						fill_stale <= 1'b0;
					end
				end
				cache_pkg::FILL: begin
					if (snoop_fill)
						fill_stale <= 1'b1;
					if (!mem.waitrequest) begin
						if (!fill_stale && !snoop_fill)
							valid[req_index] <= 1'b1;         // install only a clean fill
						state <= cache_pkg::DONE;
					end
				end
				cache_pkg::WAIT_TOKEN: begin
					if (have_token || token_in)
						state <= cache_pkg::MEM_WRITE;
				end
				cache_pkg::MEM_WRITE: begin
					if (!mem.waitrequest)
						state <= cache_pkg::SEND_INV;
				end
				cache_pkg::SEND_INV: begin
					if (inject)
						state <= cache_pkg::WAIT_INV;
				end
				cache_pkg::WAIT_INV: begin
					if (own_back)
						state <= cache_pkg::DONE;            // message removed here
				end
				default: state <= cache_pkg::IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == cache_pkg::IDLE && (core_read || core_write)) begin
			req_line <= core_address[cache_pkg::WORD_OFFSET_BITS +: cache_pkg::LINE_ADDR_BITS];
			req_word <= core_address[cache_pkg::WORD_OFFSET_BITS-1:0];
			req_write <= core_write;
			req_wdata <= core_writedata;
			req_be <= core_byteenable;
		end

		if (inject)
			out_msg <= '{op: ring_pkg::OP_INV, origin: ring_pkg::node_id_t'(NODE_ID), addr: req_line};
		else if (take && !own_back)
			out_msg <= ring_in.msg;                           // forward as received

		if (state == cache_pkg::LOOKUP)
			rdata <= lines[req_index][{req_word, 5'b00000} +: 32];

		if (state == cache_pkg::FILL && !mem.waitrequest) begin
			rdata <= mem.readdata[{req_word, 5'b00000} +: 32];
			if (!fill_stale && !snoop_fill) begin
				tags[req_index] <= req_tag;
				lines[req_index] <= mem.readdata;
			end
		end

		// keep own copy current on a write hit
		if (state == cache_pkg::MEM_WRITE && !mem.waitrequest && hit) begin
			for (int b = 0; b < cache_pkg::WORD_BYTES; b++) begin
				if (req_be[b])
					lines[req_index][{req_word, 5'b00000} + b * 8 +: 8] <= req_wdata[b * 8 +: 8];
			end
		end
	end

endmodule

// File: design/ring_if.sv
`timescale 1ns/1ps

// one hop of the ring, node i to node i+1
interface ring_if;

	ring_pkg::ring_msg_t msg;
	logic msg_valid;
	logic msg_ready;                                          // driven by the receiver
	logic token;
	logic token_valid;                                        // single cycle pulse

	modport send (
		output msg,
		output msg_valid,
		input  msg_ready,
		output token,
		output token_valid
	);

	modport receive (
		input  msg,
		input  msg_valid,
		output msg_ready,
		input  token,
		input  token_valid
	);

endinterface

// File: design/mem_if.sv
`timescale 1ns/1ps

// memory master port of one cache node
interface mem_if;

	logic [31:0] address;                                     // byte address, line aligned
	logic read;
	logic write;
	cache_pkg::line_t writedata;
	logic [cache_pkg::LINE_BYTES-1:0] byteenable;
	cache_pkg::line_t readdata;
	logic waitrequest;

	modport master (
		output address,
		output read,
		output write,
		output writedata,
		output byteenable,
		input  readdata,
		input  waitrequest
	);

	modport slave (
		input  address,
		input  read,
		input  write,
		input  writedata,
		input  byteenable,
		output readdata,
		output waitrequest
	);

endinterface

// File: design/ring_pkg.sv
package ring_pkg;

	localparam int NODE_ID_BITS = 2;

	typedef logic [NODE_ID_BITS-1:0] node_id_t;

	// ring opcodes
	typedef enum logic {
		OP_NONE = 1'b0,
		OP_INV  = 1'b1                                        // drop the line everywhere
	} ring_op_e;

	// one message slot on a ring hop
	typedef struct packed {
		ring_op_e              op;
		node_id_t              origin;                        // node that sent it
		cache_pkg::line_addr_t addr;
	} ring_msg_t;

endpackage

// File: design/cache_pkg.sv
package cache_pkg;

	// word and line geometry
	localparam int WORD_BITS = 32;
	localparam int WORD_BYTES = WORD_BITS / 8;
	localparam int LINE_WORDS = 4;                            // four words per line
	localparam int LINE_BITS = WORD_BITS * LINE_WORDS;
	localparam int LINE_BYTES = LINE_BITS / 8;

	// address split of a 32-bit byte address
	localparam int BYTE_OFFSET_BITS = 4;                      // byte within a line
	localparam int WORD_OFFSET_BITS = 2;                      // word within a line
	localparam int WORD_ADDR_BITS = 30;
	localparam int LINE_ADDR_BITS = WORD_ADDR_BITS - WORD_OFFSET_BITS;

	typedef logic [WORD_BITS-1:0] word_t;
	typedef logic [LINE_BITS-1:0] line_t;                     // one full cache line
	typedef logic [WORD_ADDR_BITS-1:0] word_addr_t;           // core side word address
	typedef logic [LINE_ADDR_BITS-1:0] line_addr_t;           // tag and index together

	// per-node controller states
	typedef enum logic [2:0] {
		IDLE       = 3'd0,
		LOOKUP     = 3'd1,                                    // tag compare
		FILL       = 3'd2,                                    // line read from memory
		WAIT_TOKEN = 3'd3,
		MEM_WRITE  = 3'd4,                                    // write through
		SEND_INV   = 3'd5,
		WAIT_INV   = 3'd6,                                    // own message on the ring
		DONE       = 3'd7
	} node_state_e;

endpackage
